//--- rtl/decodePkg.sv
//**************************************
// Shared widths, instruction field positions and control types of the decode stage.
// Imported by wildcard in every design module and reused by the testbench.
//**************************************
package decodePkg;

	localparam int dataW    = 32;           // scalar word
	localparam int vecW     = 256;          // vector word, eight 32-bit lanes
	localparam int regAddrW = 5;            // register index
	localparam int numRegs  = 2**regAddrW;  // registers per file
	localparam int instrW   = 32;           // instruction word

	typedef logic [dataW-1:0]    wordT;
	typedef logic [vecW-1:0]     vecWordT;
	typedef logic [regAddrW-1:0] regAddrT;
	typedef logic [instrW-1:0]   instrT;

	// program counter alias in the scalar file
	localparam regAddrT pcRegIdx = 5'd15;   // read returns pc plus eight

	// opcode bits, as positions in the instruction word
	localparam int vecBit  = 31;            // vector datapath
	localparam int memBit  = 30;            // memory access
	localparam int immBit  = 29;            // immediate operand
	localparam int jcBit   = 28;            // jump or compare / store
	localparam int selMsb  = 27;            // execute unit select
	localparam int selLsb  = 26;
	localparam int opcodeW = vecBit - selLsb + 1;

	// register and function fields
	localparam int rdMsb   = 25;
	localparam int rdLsb   = 21;
	localparam int rsMsb   = 20;
	localparam int rsLsb   = 16;
	localparam int rtMsb   = 15;
	localparam int rtLsb   = 11;
	localparam int funcMsb = 2;
	localparam int funcLsb = 0;

	// immediate sources inside the low 26 bits
	localparam int fieldW   = 26;           // jump offset 25..0
	localparam int imm16W   = 16;           // data and memory immediate
	localparam int shamtMsb = 10;           // shift amount 10..3
	localparam int shamtLsb = 3;

	typedef enum logic [1:0] {
		immZero16 = 2'd0,                   // 15..0 zero extended
		immSign16 = 2'd1,                   // 15..0 sign extended
		immJump26 = 2'd2,                   // 25..0 sign extended, times four
		immShamt  = 2'd3                    // 10..3 zero extended
	} immSrcT;

	typedef logic [2:0] aluOpT;             // same code as the func field
	localparam aluOpT aluAdd = 3'd0;
	localparam aluOpT aluShl = 3'd5;
	localparam aluOpT aluShr = 3'd6;

	typedef logic [1:0] instrSelT;          // execute unit selector
	localparam instrSelT selJump = 2'd3;    // with jc set, marks jump/branch

endpackage

//--- rtl/ctrlIf.sv
//**************************************
// Control bundle from the decoder to the operand fetch, extender and stage top.
// Driven only by controlUnit; all other users see it read only.
//**************************************
interface ctrlIf import decodePkg::*; ();

	logic     pcSrc, regWrite, regWriteV;  // fetch redirect and register writes
	logic     memtoReg;                    // writeback takes memory data
	logic     memWrite, memSrc;            // store enable and memory select
	logic     memData, memDataV, vecData;  // store source and vector transfer
	logic     branch, aluSrc;              // conditional branch and imm operand
	instrSelT instrSel;                    // execute unit
	aluOpT    aluControl;
	logic     [1:0] regSrc;                // bit 0 reads r15, bit 1 reads rd
	immSrcT   immSrc;

	modport unit (output pcSrc, regWrite, regWriteV, memtoReg, memWrite, memSrc,
		memData, memDataV, vecData, branch, aluSrc, instrSel, aluControl,
		regSrc, immSrc);

	modport fetch (input regSrc);          // read address muxes
	modport ext (input immSrc);            // immediate extender

	modport stage (input pcSrc, regWrite, regWriteV, memtoReg, memWrite, memSrc,
		memData, memDataV, vecData, branch, aluSrc, instrSel, aluControl);

endinterface

//--- rtl/controlUnit.sv
//**************************************
// Combinational main decoder. Classifies the opcode into one of five
// instruction classes and drives the whole control bundle.
//**************************************
module controlUnit import decodePkg::*; (
	input  logic [opcodeW-1:0] opcode,  // instruction bits 31..26
	input  aluOpT              func,    // instruction bits 2..0
	input  regAddrT            rd,      // destination, for the r15 redirect
	ctrlIf.unit                ctrl
);

	typedef enum logic [2:0] {
		clsData,                        // alu and shift, scalar or vector
		clsCmp,                         // compare, no write
		clsJump,                        // jump or conditional branch
		clsLoad,
		clsStore
	} classT;

	logic     v, m, i, jc;              // opcode flags
	instrSelT sel;
	classT    cls;
	logic     regWr;                    // local copy for the pc redirect

	assign v   = opcode[vecBit - selLsb];
	assign m   = opcode[memBit - selLsb];
	assign i   = opcode[immBit - selLsb];
	assign jc  = opcode[jcBit - selLsb];
	assign sel = opcode[selMsb - selLsb:0];

	always_comb begin
		if (!m && !jc)
			cls = clsData;
		else if (!m && sel != selJump)
			cls = clsCmp;
		else if (!m)
			cls = clsJump;              // jc set with sel 3
		else if (!jc)
			cls = clsLoad;
		else
			cls = clsStore;
	end

	always_comb begin
		// everything idles unless the class says otherwise
		regWr           = 1'b0;
		ctrl.pcSrc      = 1'b0;
		ctrl.regWriteV  = 1'b0;
		ctrl.memtoReg   = 1'b0;
		ctrl.memWrite   = 1'b0;
		ctrl.memSrc     = 1'b0;
		ctrl.memData    = 1'b0;
		ctrl.memDataV   = 1'b0;
		ctrl.vecData    = 1'b0;
		ctrl.branch     = 1'b0;
		ctrl.aluSrc     = 1'b0;
		ctrl.aluControl = aluAdd;
		ctrl.regSrc     = 2'b00;
		ctrl.immSrc     = immZero16;
		ctrl.instrSel   = sel;          // passed on in every class

		case (cls)
			clsData: begin
				regWr           = ~v;
				ctrl.regWriteV  = v;
				ctrl.aluControl = func;
				ctrl.aluSrc     = i;
				if (func == aluShl || func == aluShr)
					ctrl.immSrc = immShamt;  // shift amount in 10..3
			end
			clsCmp: begin
				ctrl.aluControl = func;  // flags only
				ctrl.aluSrc     = i;
			end
			clsJump: begin
				ctrl.regSrc[0]  = 1'b1;  // base is r15, i.e. pc plus eight
				ctrl.aluSrc     = 1'b1;
				ctrl.immSrc     = immJump26;
				ctrl.pcSrc      = (func == '0);  // unconditional
				ctrl.branch     = (func != '0);  // resolved in execute
			end
			clsLoad: begin
				regWr           = ~v;
				ctrl.regWriteV  = v;
				ctrl.memtoReg   = 1'b1;
				ctrl.vecData    = v;
			end
			default: begin               // clsStore
				ctrl.memWrite   = 1'b1;
				ctrl.regSrc[1]  = 1'b1;  // store data comes from rd
				ctrl.memData    = ~v;
				ctrl.memDataV   = v;
				ctrl.vecData    = v;
			end
		endcase

		if (m) begin                     // address is base plus signed offset
			ctrl.aluSrc     = i;
			ctrl.aluControl = aluAdd;
			ctrl.immSrc     = immSign16;
			ctrl.memSrc     = sel[0];
		end

		// writing r15 redirects fetch
		if (regWr && rd == pcRegIdx)
			ctrl.pcSrc = 1'b1;
		ctrl.regWrite = regWr;
	end

endmodule

//--- rtl/immExtend.sv
//**************************************
// Immediate extender. Builds the 32-bit operand from the low
// instruction bits in the mode chosen by the decoder.
//**************************************
module immExtend import decodePkg::*; (
	input  logic [fieldW-1:0] field,    // instruction bits 25..0
	ctrlIf.ext                ctrl,
	output wordT              extImm
);

	localparam int shamtW = shamtMsb - shamtLsb + 1;

	logic [imm16W-1:0] imm16;           // data and memory immediate
	logic [shamtW-1:0] shamt;

	assign imm16 = field[imm16W-1:0];
	assign shamt = field[shamtMsb:shamtLsb];

	always_comb begin
		unique case (ctrl.immSrc)
			immZero16:
				extImm = {{(dataW - imm16W){1'b0}}, imm16};
			immSign16:
				extImm = {{(dataW - imm16W){imm16[imm16W-1]}}, imm16};
			immJump26:  // word offset, byte aligned
				extImm = {{(dataW - fieldW - 2){field[fieldW-1]}}, field, 2'b00};
			immShamt:
				extImm = {{(dataW - shamtW){1'b0}}, shamt};
		endcase
	end

endmodule

//--- rtl/regFile.sv
//**************************************
// Register file with two combinational read ports and one clocked
// write port. The word type selects scalar or vector payload.
//**************************************
module regFile import decodePkg::*; #(
	parameter type wordType = wordT
) (
	input  logic    clk,
	input  logic    rstN,
	input  regAddrT ra1,                // read port 1
	input  regAddrT ra2,                // read port 2
	input  regAddrT wa,                 // write address from writeback
	input  logic    we,
	input  wordType wd,
	output wordType rd1,
	output wordType rd2
);

	wordType regs [numRegs];

	// write on the rising edge, visible to reads from the next cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int r = 0; r < numRegs; r++)
				regs[r] <= '0;          // whole file cleared
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// no write bypass here, forwarding lives in the hazard unit
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

//--- rtl/operandFetch.sv
//**************************************
// Operand fetch. Muxes the read addresses, reads the scalar and vector
// files at the same addresses and maps r15 to pc plus eight.
//**************************************
module operandFetch import decodePkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  regAddrT rs,
	input  regAddrT rt,
	input  regAddrT rd,
	input  regAddrT wa3W,               // writeback destination
	input  logic    regWriteW,          // scalar write enable
	input  logic    regWriteVW,         // vector write enable
	input  wordT    resultW,
	input  vecWordT resultVW,
	input  wordT    pcPlus8,
	ctrlIf.fetch    ctrl,
	output regAddrT ra1,                // also to the hazard unit
	output regAddrT ra2,
	output wordT    rd1,
	output wordT    rd2,
	output vecWordT vrd1,
	output vecWordT vrd2
);

	wordT sRd1, sRd2;                   // raw scalar reads

	assign ra1 = ctrl.regSrc[0] ? pcRegIdx : rs;  // jumps use pc as base
	assign ra2 = ctrl.regSrc[1] ? rd : rt;        // stores read rd

	regFile #(.wordType(wordT)) uScalar (
		.clk  (clk),
		.rstN (rstN),
		.ra1  (ra1),
		.ra2  (ra2),
		.wa   (wa3W),
		.we   (regWriteW),
		.wd   (resultW),
		.rd1  (sRd1),
		.rd2  (sRd2)
	);

	regFile #(.wordType(vecWordT)) uVector (
		.clk  (clk),
		.rstN (rstN),
		.ra1  (ra1),
		.ra2  (ra2),
		.wa   (wa3W),
		.we   (regWriteVW),
		.wd   (resultVW),
		.rd1  (vrd1),
		.rd2  (vrd2)
	);

	// r15 is not stored, the fetch stage supplies it
	assign rd1 = (ra1 == pcRegIdx) ? pcPlus8 : sRd1;
	assign rd2 = (ra2 == pcRegIdx) ? pcPlus8 : sRd2;

endmodule

//--- rtl/decodeStage.sv
//**************************************
// Decode stage top. Splits the instruction, runs the decoder, the operand
// fetch and the extender, and exports the control word as plain ports.
//**************************************
module decodeStage import decodePkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  instrT    instrD,            // from the fetch/decode register
	input  logic     regWriteW,         // writeback scalar enable
	input  logic     regWriteVW,        // writeback vector enable
	input  wordT     pcPlus8D,
	input  regAddrT  wa3W,
	input  wordT     resultW,
	input  vecWordT  resultVW,

	// control word for the decode/execute register
	output logic     pcSrcD,
	output logic     regWriteD,
	output logic     regWriteVD,
	output logic     memtoRegD,
	output logic     memWriteD,
	output logic     memSrcD,
	output logic     memDataD,
	output logic     memDataVD,
	output logic     vecDataD,
	output instrSelT instrSelD,
	output aluOpT    aluControlD,
	output logic     branchD,
	output logic     aluSrcD,

	// addresses and operands
	output regAddrT  ra1DH,             // to the hazard unit as well
	output regAddrT  ra2DH,
	output wordT     rd1D,
	output wordT     rd2D,
	output vecWordT  vrd1D,
	output vecWordT  vrd2D,
	output regAddrT  wa3D,
	output wordT     extImmD
);

	logic [opcodeW-1:0] opcode;         // v m i jc sel
	regAddrT            rdF, rsF, rtF;
	aluOpT              func;
	logic [fieldW-1:0]  immField;       // jump, imm16 and shamt all live here

	assign opcode   = instrD[vecBit:selLsb];
	assign rdF      = instrD[rdMsb:rdLsb];
	assign rsF      = instrD[rsMsb:rsLsb];
	assign rtF      = instrD[rtMsb:rtLsb];
	assign func     = instrD[funcMsb:funcLsb];
	assign immField = instrD[fieldW-1:0];

	ctrlIf ctrl ();

	controlUnit uCtrl (
		.opcode (opcode),
		.func   (func),
		.rd     (rdF),
		.ctrl   (ctrl.unit)
	);

	operandFetch uFetch (
		.clk        (clk),
		.rstN       (rstN),
		.rs         (rsF),
		.rt         (rtF),
		.rd         (rdF),
		.wa3W       (wa3W),
		.regWriteW  (regWriteW),
		.regWriteVW (regWriteVW),
		.resultW    (resultW),
		.resultVW   (resultVW),
		.pcPlus8    (pcPlus8D),
		.ctrl       (ctrl.fetch),
		.ra1        (ra1DH),
		.ra2        (ra2DH),
		.rd1        (rd1D),
		.rd2        (rd2D),
		.vrd1       (vrd1D),
		.vrd2       (vrd2D)
	);

	immExtend uExt (
		.field  (immField),
		.ctrl   (ctrl.ext),
		.extImm (extImmD)
	);

	assign wa3D = rdF;                  // destination rides down the pipe

	// bundle out to plain ports
	assign pcSrcD      = ctrl.pcSrc;
	assign regWriteD   = ctrl.regWrite;
	assign regWriteVD  = ctrl.regWriteV;
	assign memtoRegD   = ctrl.memtoReg;
	assign memWriteD   = ctrl.memWrite;
	assign memSrcD     = ctrl.memSrc;
	assign memDataD    = ctrl.memData;
	assign memDataVD   = ctrl.memDataV;
	assign vecDataD    = ctrl.vecData;
	assign instrSelD   = ctrl.instrSel;
	assign aluControlD = ctrl.aluControl;
	assign branchD     = ctrl.branch;
	assign aluSrcD     = ctrl.aluSrc;

endmodule

//--- tb/tbDecode.sv
//**************************************
// Testbench for the decode stage. Drives instructions and writeback traffic,
// checks every output against a reference decode and shadow register files.
//**************************************
module tbDecode import decodePkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int numWrites   = 16;    // write/readback rounds per file
	localparam int numRandom   = 500;
	localparam int numDirected = 12;
	localparam int testCount   = 2 * numRegs + 6 * numWrites + numRandom + numDirected + 6;

	typedef struct packed {
		logic     pcSrc, regWrite, regWriteV, memtoReg, memWrite, memSrc;
		logic     memData, memDataV, vecData, branch, aluSrc;
		instrSelT instrSel;
		aluOpT    aluControl;
		regAddrT  ra1, ra2, wa3;
		wordT     extImm;
	} expectT;

	logic     clk, rstN, regWriteW, regWriteVW;
	instrT    instrD;
	wordT     pcPlus8D, resultW;
	regAddrT  wa3W;
	vecWordT  resultVW;
	logic     pcSrcD, regWriteD, regWriteVD, memtoRegD, memWriteD, memSrcD;
	logic     memDataD, memDataVD, vecDataD, branchD, aluSrcD;
	instrSelT instrSelD;
	aluOpT    aluControlD;
	regAddrT  ra1DH, ra2DH, wa3D;
	wordT     rd1D, rd2D, extImmD;
	vecWordT  vrd1D, vrd2D;

	wordT    shadowS [numRegs];         // mirrors of the two files
	vecWordT shadowV [numRegs];
	expectT  exp;
	logic    checking;
	int      seed, errCount, checkCount;

	instrT directed [numDirected] = '{
		{6'b001000, 26'h000_8001},      // data imm in zero16 mode with bit 15 set
		{6'b001000, 26'h000_00AD},      // shift func 5 in shamt mode
		{6'b001000, 26'h000_07F6},      // shift func 6 with shamt 0xfe
		{6'b011000, 26'h000_1234},      // load with positive offset
		{6'b011001, 26'h000_F00C},      // load with negative offset and memSrc 1
		{6'b111100, 26'h02A_8004},      // vector store with negative offset
		{6'b000111, 26'h3FF_FFF8},      // jump back with pcSrc
		{6'b000111, 26'h000_0101},      // conditional branch forward
		{6'b000000, 26'h1E0_0000},      // scalar write to r15
		{6'b100000, 26'h1E0_0000},      // vector write to r15 without redirect
		{6'b010000, 26'h1E0_0000},      // load into r15
		{6'b000100, 26'h000_0003}       // compare writes nothing
	};

	decodeStage UUT (.*);

	always #5 clk = ~clk;               // 10 ns period

	function automatic wordT randWord();
		return $random(seed);
	endfunction

	function automatic vecWordT randVec();
		vecWordT v;
		for (int k = 0; k < 8; k++)
			v[k*32 +: 32] = randWord();
		return v;
	endfunction

	// reads register a on both ports with rd at r0
	function automatic instrT readInstr(regAddrT a);
		return {6'b000000, 5'd0, a, a, 11'd0};
	endfunction

	// expected control word, addresses and immediate of one instruction
	function automatic expectT decodeRef(instrT ins);
		logic     v, m, i, jc;
		instrSelT sel;
		aluOpT    fn;
		regAddrT  rd, rs, rt;
		immSrcT   imm;
		logic [1:0] src;
		expectT   e;
		v   = ins[31];
		m   = ins[30];
		i   = ins[29];
		jc  = ins[28];
		sel = ins[27:26];
		fn  = ins[2:0];
		rd  = ins[25:21];
		rs  = ins[20:16];
		rt  = ins[15:11];
		e   = '0;
		src = 2'b00;
		imm = immZero16;
		e.instrSel = sel;
		if (!m) begin
			if (!jc) begin                      // data processing
				e.regWrite   = !v;
				e.regWriteV  = v;
				e.aluControl = fn;
				e.aluSrc     = i;
				if (fn == 3'd5 || fn == 3'd6)
					imm = immShamt;
			end else if (sel != 2'd3) begin     // compare
				e.aluControl = fn;
				e.aluSrc     = i;
			end else begin                      // jump or branch
				src[0]   = 1'b1;
				e.aluSrc = 1'b1;
				imm      = immJump26;
				e.pcSrc  = (fn == 3'd0);
				e.branch = (fn != 3'd0);
			end
		end else begin
			e.aluSrc = i;
			e.memSrc = sel[0];
			imm      = immSign16;
			if (!jc) begin                      // load
				e.regWrite  = !v;
				e.regWriteV = v;
				e.memtoReg  = 1'b1;
				e.vecData   = v;
			end else begin                      // store
				e.memWrite = 1'b1;
				src[1]     = 1'b1;
				e.memData  = !v;
				e.memDataV = v;
				e.vecData  = v;
			end
		end
		if (e.regWrite && rd == 5'd15)
			e.pcSrc = 1'b1;
		e.ra1 = src[0] ? 5'd15 : rs;
		e.ra2 = src[1] ? rd : rt;
		e.wa3 = rd;
		case (imm)
			immZero16: e.extImm = {16'h0000, ins[15:0]};
			immSign16: e.extImm = {{16{ins[15]}}, ins[15:0]};
			immJump26: e.extImm = {{6{ins[25]}}, ins[25:0]} << 2;
			default:   e.extImm = 32'(ins[10:3]);
		endcase
		return e;
	endfunction

	task automatic checkVal(string what, vecWordT got, vecWordT want);
		checkCount++;
		if (got !== want) begin
			errCount++;
			$display("ERROR at time %0t: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	task automatic clearShadows();
		for (int k = 0; k < numRegs; k++) begin
			shadowS[k] = '0;
			shadowV[k] = '0;
		end
	endtask

	// one cycle of stimulus, applied on the falling edge
	task automatic drive(instrT ins, logic we, logic weV, regAddrT wa, wordT wd,
		vecWordT wdV);
		@(negedge clk);
		instrD     = ins;
		regWriteW  = we;
		regWriteVW = weV;
		wa3W       = wa;
		resultW    = wd;
		resultVW   = wdV;
		pcPlus8D   = randWord();            // fresh pc every cycle
	endtask

	// compare just before each rising edge, then mirror the pending write
	always begin
		@(negedge clk);
		#4;
		if (checking) begin
			exp = decodeRef(instrD);
			checkVal("pcSrcD", vecWordT'(pcSrcD), vecWordT'(exp.pcSrc));
			checkVal("regWriteD", vecWordT'(regWriteD), vecWordT'(exp.regWrite));
			checkVal("regWriteVD", vecWordT'(regWriteVD), vecWordT'(exp.regWriteV));
			checkVal("memtoRegD", vecWordT'(memtoRegD), vecWordT'(exp.memtoReg));
			checkVal("memWriteD", vecWordT'(memWriteD), vecWordT'(exp.memWrite));
			checkVal("memSrcD", vecWordT'(memSrcD), vecWordT'(exp.memSrc));
			checkVal("memDataD", vecWordT'(memDataD), vecWordT'(exp.memData));
			checkVal("memDataVD", vecWordT'(memDataVD), vecWordT'(exp.memDataV));
			checkVal("vecDataD", vecWordT'(vecDataD), vecWordT'(exp.vecData));
			checkVal("branchD", vecWordT'(branchD), vecWordT'(exp.branch));
			checkVal("aluSrcD", vecWordT'(aluSrcD), vecWordT'(exp.aluSrc));
			checkVal("instrSelD", vecWordT'(instrSelD), vecWordT'(exp.instrSel));
			checkVal("aluControlD", vecWordT'(aluControlD), vecWordT'(exp.aluControl));
			checkVal("ra1DH", vecWordT'(ra1DH), vecWordT'(exp.ra1));
			checkVal("ra2DH", vecWordT'(ra2DH), vecWordT'(exp.ra2));
			checkVal("wa3D", vecWordT'(wa3D), vecWordT'(exp.wa3));
			checkVal("extImmD", vecWordT'(extImmD), vecWordT'(exp.extImm));
			checkVal("rd1D", vecWordT'(rd1D),
				vecWordT'((exp.ra1 == pcRegIdx) ? pcPlus8D : shadowS[exp.ra1]));
			checkVal("rd2D", vecWordT'(rd2D),
				vecWordT'((exp.ra2 == pcRegIdx) ? pcPlus8D : shadowS[exp.ra2]));
			checkVal("vrd1D", vrd1D, shadowV[exp.ra1]);
			checkVal("vrd2D", vrd2D, shadowV[exp.ra2]);
			if (regWriteW)
				shadowS[wa3W] = resultW;    // lands at the coming edge
			if (regWriteVW)
				shadowV[wa3W] = resultVW;
		end
	end

	initial begin : stimulus
		wordT    r;
		regAddrT a;
		wordT    d;
		vecWordT dv;
		clk = 1'b0;
		rstN = 1'b0;
		instrD = '0;
		regWriteW = 1'b0;
		regWriteVW = 1'b0;
		wa3W = '0;
		resultW = '0;
		resultVW = '0;
		pcPlus8D = '0;
		checking = 1'b0;
		seed = 18;
		errCount = 0;
		checkCount = 0;
		clearShadows();
		repeat (4) @(negedge clk);          // reset for four cycles
		rstN = 1'b1;
		checking = 1'b1;

		for (int k = 0; k < numRegs; k++)   // fill both files with nonzero data
			drive(readInstr(regAddrT'(k)), 1'b1, 1'b1, regAddrT'(k), randWord(), randVec());

		@(negedge clk);                     // second reset clears the filled files
		checking = 1'b0;
		regWriteW = 1'b0;
		regWriteVW = 1'b0;
		rstN = 1'b0;
		@(negedge clk);
		rstN = 1'b1;
		clearShadows();
		checking = 1'b1;

		for (int k = 0; k < numRegs; k++)   // all zero after reset except r15 as pc
			drive(readInstr(regAddrT'(k)), 1'b0, 1'b0, '0, '0, '0);

		for (int n = 0; n < numWrites; n++) begin  // scalar write and readback
			r = randWord();
			a = r[4:0];
			d = randWord();
			drive(readInstr(a), 1'b1, 1'b0, a, d, '0);
			drive(readInstr(a), 1'b0, 1'b0, a, randWord(), randVec());
			drive(readInstr(a), 1'b0, 1'b0, a, randWord(), randVec());
		end

		for (int n = 0; n < numWrites; n++) begin  // vector write leaves scalar untouched
			r = randWord();
			a = r[4:0];
			dv = randVec();
			drive(readInstr(a), 1'b0, 1'b1, a, randWord(), dv);
			drive(readInstr(a), 1'b0, 1'b0, a, randWord(), randVec());
			drive(readInstr(a), 1'b0, 1'b0, a, randWord(), randVec());
		end

		for (int n = 0; n < numRandom; n++) begin  // random decode with traffic
			r = randWord();
			a = r[4:0];
			drive(randWord(), r[9:8] == 2'b00, r[11:10] == 2'b00, a, randWord(), randVec());
		end

		foreach (directed[k])               // immediate modes and redirects
			drive(directed[k], 1'b0, 1'b0, '0, '0, '0);

		repeat (2) @(negedge clk);          // let the last compare run
		checking = 1'b0;
		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin : watchdog
		#((testCount + 200) * 10);
		$display("Timeout: the test did not finish in the expected time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

//--- project.f
rtl/decodePkg.sv
rtl/ctrlIf.sv
rtl/controlUnit.sv
rtl/immExtend.sv
rtl/regFile.sv
rtl/operandFetch.sv
rtl/decodeStage.sv
tb/tbDecode.sv

//--- Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tbDecode
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
